/* vlog.f */
src/isa_pkg.sv
src/trap_pkg.sv
src/alu_path.sv
src/trap_check.sv
src/result_merge.sv
src/exec_unit.sv
bench/exec_unit_tb.sv

/* Bender.yml */
package:
  name: exec_unit

sources:
  - src/isa_pkg.sv
  - src/trap_pkg.sv
  - src/alu_path.sv
  - src/trap_check.sv
  - src/result_merge.sv
  - src/exec_unit.sv
  - target: test
    files:
      - bench/exec_unit_tb.sv

/* bench/exec_unit_tb.sv */
`timescale 1ns/1ps

module exec_unit_tb;
	import isa_pkg::*;
	import trap_pkg::*;

	localparam int TIMEOUT_CYCLES = 40;

	logic   clk;
	logic   rst;
	logic   i_req;
	addr_t  i_pc;
	inst_t  i_inst;
	word_t  i_rs1_data;
	word_t  i_rs2_data;
	logic   o_ack;
	word_t  o_result;
	addr_t  o_mem_addr;
	logic   o_redirect;
	addr_t  o_target;
	logic   o_expt_valid;
	cause_t o_expt_cause;
	word_t  o_expt_value;

	// Expected outputs of the transaction in flight
	word_t  exp_result;
	addr_t  exp_mem_addr;
	logic   exp_redirect;
	addr_t  exp_target;
	logic   exp_expt_valid;
	cause_t exp_cause;
	word_t  exp_value;
	logic   chk_result;
	logic   chk_target;
	logic   chk_mem;

	int          err_value;
	int          err_handshake;
	int          err_timeout;
	int          n_trans;

	exec_unit exec_unit_inst (
		.clk          (clk),
		.rst          (rst),
		.i_req        (i_req),
		.i_pc         (i_pc),
		.i_inst       (i_inst),
		.i_rs1_data   (i_rs1_data),
		.i_rs2_data   (i_rs2_data),
		.o_ack        (o_ack),
		.o_result     (o_result),
		.o_mem_addr   (o_mem_addr),
		.o_redirect   (o_redirect),
		.o_target     (o_target),
		.o_expt_valid (o_expt_valid),
		.o_expt_cause (o_expt_cause),
		.o_expt_value (o_expt_value)
	);

	always #2 clk = ~clk;

	task automatic value_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		err_value++;
		$display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, want);
	endtask

	task automatic handshake_fault(input string what);
		err_handshake++;
		$display("Handshake error at t=%0t: %s", $time, what);
	endtask

	task automatic finish_run;
		$display("Errors: value %0d, handshake %0d, timeout %0d after %0d transactions",
			err_value, err_handshake, err_timeout, n_trans);
		if (err_value + err_handshake + err_timeout == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	endtask

	// Handshake timing
	a_ack_rise: assert property (@(posedge clk) disable iff (!rst) i_req && !o_ack |=> o_ack)
		else handshake_fault("o_ack did not rise one cycle after i_req was sampled");
	a_ack_fall: assert property (@(posedge clk) disable iff (!rst) !i_req && o_ack |=> !o_ack)
		else handshake_fault("o_ack did not fall one cycle after i_req dropped");
	a_no_ack: assert property (@(posedge clk) disable iff (!rst) !i_req && !o_ack |=> !o_ack)
		else handshake_fault("o_ack rose without a request");
	a_hold: assert property (@(posedge clk) disable iff (!rst) i_req && o_ack |=>
		o_ack && $stable({o_result, o_mem_addr, o_redirect, o_target, o_expt_valid,
		o_expt_cause, o_expt_value}))
		else handshake_fault("o_ack or the outputs changed during back-pressure");

	// Output values at the o_ack rise
	a_redirect: assert property (@(posedge clk) disable iff (!rst)
		$rose(o_ack) |-> o_redirect == exp_redirect)
		else value_mismatch("o_redirect", 32'($sampled(o_redirect)), 32'(exp_redirect));
	a_expt_valid: assert property (@(posedge clk) disable iff (!rst)
		$rose(o_ack) |-> o_expt_valid == exp_expt_valid)
		else value_mismatch("o_expt_valid", 32'($sampled(o_expt_valid)), 32'(exp_expt_valid));
	a_cause: assert property (@(posedge clk) disable iff (!rst)
		$rose(o_ack) && exp_expt_valid |-> o_expt_cause == exp_cause)
		else value_mismatch("o_expt_cause", 32'($sampled(o_expt_cause)), 32'(exp_cause));
	a_value: assert property (@(posedge clk) disable iff (!rst)
		$rose(o_ack) && exp_expt_valid |-> o_expt_value == exp_value)
		else value_mismatch("o_expt_value", $sampled(o_expt_value), exp_value);
	a_result: assert property (@(posedge clk) disable iff (!rst)
		$rose(o_ack) && chk_result |-> o_result == exp_result)
		else value_mismatch("o_result", $sampled(o_result), exp_result);
	a_target: assert property (@(posedge clk) disable iff (!rst)
		$rose(o_ack) && chk_target |-> o_target == exp_target)
		else value_mismatch("o_target", $sampled(o_target), exp_target);
	a_mem_addr: assert property (@(posedge clk) disable iff (!rst)
		$rose(o_ack) && chk_mem |-> o_mem_addr == exp_mem_addr)
		else value_mismatch("o_mem_addr", $sampled(o_mem_addr), exp_mem_addr);

	function automatic word_t alu_model(input funct3_t f3, input logic sub, input logic arith,
		input word_t a, input word_t b);
		word_t      r;
		logic [4:0] sh;
		sh = b[4:0];
		case (f3)
			3'b000: r = sub ? a - b : a + b;
			3'b001: r = a << sh;
			3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: r = (a < b) ? 32'd1 : 32'd0;
			3'b100: r = a ^ b;
			3'b101: begin
				if (arith) begin
					r = $signed(a) >>> sh;
				end else begin
					r = a >> sh;
				end
			end
			3'b110: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	// Reference model of one instruction, straight from the RV32I rules
	function automatic void model_outputs(input addr_t pc, input inst_t inst, input word_t a,
		input word_t b);
		logic [6:0] opc;
		logic [6:0] f7;
		funct3_t    f3;
		word_t      imm_i;
		word_t      imm_s;
		word_t      imm_b;
		word_t      imm_u;
		word_t      imm_j;
		addr_t      tgt;
		addr_t      addr;
		logic       taken;
		logic       bad;
		logic       mis;
		opc = inst[6:0];
		f3 = inst[14:12];
		f7 = inst[31:25];
		imm_i = $signed(inst) >>> 20;
		imm_s = {imm_i[31:5], inst[11:7]};
		imm_b = {imm_i[31:12], inst[7], inst[30:25], inst[11:8], 1'b0};
		imm_u = {inst[31:12], 12'h000};
		imm_j = {imm_i[31:20], inst[19:12], inst[20], inst[30:21], 1'b0};
		tgt = '0;
		addr = '0;
		taken = 1'b0;
		bad = 1'b0;
		mis = 1'b0;
		exp_result = '0;
		exp_expt_valid = 1'b0;
		exp_cause = '0;
		exp_value = '0;
		chk_result = 1'b0;
		chk_target = 1'b0;
		chk_mem = 1'b0;
		case (opc)
			OPC_LUI: begin
				exp_result = imm_u;
				chk_result = 1'b1;
			end
			OPC_AUIPC: begin
				exp_result = pc + imm_u;
				chk_result = 1'b1;
			end
			OPC_OP: begin
				bad = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
				exp_result = alu_model(f3, inst[30], inst[30], a, b);
				chk_result = !bad;
			end
			OPC_OP_IMM: begin
				bad = (f3 == 3'b001 && f7 != 7'h00) ||
					(f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20);
				exp_result = alu_model(f3, 1'b0, inst[30], a, imm_i);
				chk_result = !bad;
			end
			OPC_JAL, OPC_JALR: begin
				bad = (opc == OPC_JALR) && (f3 != 3'b000);
				tgt = (opc == OPC_JAL) ? pc + imm_j : (a + imm_i) & ~32'd1;
				taken = 1'b1;
				exp_result = pc + 32'd4;
				chk_result = 1'b1;
				chk_target = 1'b1;
			end
			OPC_BRANCH: begin
				tgt = pc + imm_b;
				chk_target = 1'b1;
				case (f3)
					3'b000: taken = (a == b);
					3'b001: taken = (a != b);
					3'b100: taken = ($signed(a) < $signed(b));
					3'b101: taken = ($signed(a) >= $signed(b));
					3'b110: taken = (a < b);
					3'b111: taken = (a >= b);
					default: bad = 1'b1;
				endcase
			end
			OPC_LOAD, OPC_STORE: begin
				addr = a + ((opc == OPC_LOAD) ? imm_i : imm_s);
				chk_mem = 1'b1;
				case (f3)
					3'b000: mis = 1'b0;
					3'b001: mis = addr[0];
					3'b010: mis = (addr[1:0] != 2'b00);
					3'b100, 3'b101: begin
						bad = (opc == OPC_STORE);
						mis = (f3 == 3'b101) && addr[0];
					end
					default: bad = 1'b1;
				endcase
			end
			OPC_SYSTEM: begin
				if (inst == 32'h0000_0073) begin
					exp_expt_valid = 1'b1;
					exp_cause = 4'd11;
				end else if (inst == 32'h0010_0073) begin
					exp_expt_valid = 1'b1;
					exp_cause = 4'd3;
					exp_value = pc;
				end else begin
					bad = 1'b1;
				end
			end
			default: bad = 1'b1;
		endcase
		// Decode error first, then jump target, then data address
		if (bad) begin
			exp_expt_valid = 1'b1;
			exp_cause = 4'd2;
			exp_value = inst;
		end else if (!exp_expt_valid && taken && tgt[1:0] != 2'b00) begin
			exp_expt_valid = 1'b1;
			exp_cause = 4'd0;
			exp_value = tgt;
		end else if (!exp_expt_valid && mis) begin
			exp_expt_valid = 1'b1;
			exp_cause = (opc == OPC_LOAD) ? 4'd4 : 4'd6;
			exp_value = addr;
		end
		exp_target = tgt;
		exp_mem_addr = addr;
		exp_redirect = taken && !exp_expt_valid;
	endfunction

	function automatic reg_idx_t rand_reg();
		return reg_idx_t'($urandom);
	endfunction

	function automatic addr_t rand_pc();
		return addr_t'($urandom) & 32'hffff_fffc;
	endfunction

	function automatic inst_t r_format(input logic [6:0] f7, input funct3_t f3,
		input logic [6:0] opc);
		return {f7, rand_reg(), rand_reg(), f3, rand_reg(), opc};
	endfunction

	function automatic inst_t i_format(input logic [11:0] imm, input funct3_t f3,
		input logic [6:0] opc);
		return {imm, rand_reg(), f3, rand_reg(), opc};
	endfunction

	function automatic inst_t s_format(input logic [11:0] imm, input funct3_t f3);
		return {imm[11:5], rand_reg(), rand_reg(), f3, imm[4:0], OPC_STORE};
	endfunction

	function automatic inst_t b_format(input logic [12:0] off, input funct3_t f3);
		return {off[12], off[10:5], rand_reg(), rand_reg(), f3, off[4:1], off[11], OPC_BRANCH};
	endfunction

	function automatic inst_t u_format(input logic [19:0] imm, input logic [6:0] opc);
		return {imm, rand_reg(), opc};
	endfunction

	function automatic inst_t j_format(input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rand_reg(), OPC_JAL};
	endfunction

	task automatic check_idle;
		assert (o_ack === 1'b0) else value_mismatch("o_ack", 32'(o_ack), 32'd0);
		assert (o_redirect === 1'b0) else value_mismatch("o_redirect", 32'(o_redirect), 32'd0);
		assert (o_expt_valid === 1'b0)
			else value_mismatch("o_expt_valid", 32'(o_expt_valid), 32'd0);
		assert (o_result === '0) else value_mismatch("o_result", o_result, 32'd0);
		assert (o_target === '0) else value_mismatch("o_target", o_target, 32'd0);
		assert (o_expt_value === '0) else value_mismatch("o_expt_value", o_expt_value, 32'd0);
	endtask

	// Full four-phase transaction with a random back-pressure hold
	task automatic do_transaction(input addr_t pc, input inst_t inst, input word_t a,
		input word_t b);
		int cnt;
		int hold;
		hold = int'($urandom_range(0, 4));
		@(negedge clk);
		i_pc = pc;
		i_inst = inst;
		i_rs1_data = a;
		i_rs2_data = b;
		model_outputs(pc, inst, a, b);
		i_req = 1'b1;
		cnt = 0;
		while (!o_ack && cnt < TIMEOUT_CYCLES) begin
			@(negedge clk);
			cnt++;
		end
		if (!o_ack) begin
			err_timeout++;
			$display("Timeout: o_ack never rose for instruction %h", inst);
			finish_run();
		end else begin
			repeat (hold) @(negedge clk);
			i_req = 1'b0;
			cnt = 0;
			while (o_ack && cnt < TIMEOUT_CYCLES) begin
				@(negedge clk);
				cnt++;
			end
			if (o_ack) begin
				err_timeout++;
				$display("Timeout: o_ack stayed high after i_req dropped, instruction %h", inst);
				finish_run();
			end else begin
				n_trans++;
			end
		end
	endtask

	task automatic alu_tests;
		funct3_t     f3;
		logic [6:0]  f7;
		logic [11:0] imm;
		for (int i = 0; i < 40; i++) begin
			f3 = funct3_t'($urandom);
			f7 = ((f3 == F3_ADD_SUB || f3 == F3_SRL_SRA) && $urandom_range(0, 1) == 1) ?
				F7_ALT : F7_BASE;
			do_transaction(rand_pc(), r_format(f7, f3, OPC_OP), $urandom, $urandom);
			imm = 12'($urandom);
			if (f3 == F3_SLL || f3 == F3_SRL_SRA) begin
				imm[11:5] = (f3 == F3_SLL) ? F7_BASE : f7;
			end
			do_transaction(rand_pc(), i_format(imm, f3, OPC_OP_IMM), $urandom, $urandom);
		end
		for (int i = 0; i < 6; i++) begin
			do_transaction(rand_pc(), u_format(20'($urandom), OPC_LUI), $urandom, $urandom);
			do_transaction(rand_pc(), u_format(20'($urandom), OPC_AUIPC), $urandom, $urandom);
		end
	endtask

	task automatic branch_tests;
		funct3_t     conds [6];
		word_t       lhs [4];
		word_t       rhs [4];
		logic [12:0] off;
		logic [20:0] joff;
		logic [11:0] imm;
		conds = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
		// Equal, signed less but unsigned greater, the reverse, plain less
		lhs = '{32'd7, 32'hffff_fff0, 32'd5, 32'd3};
		rhs = '{32'd7, 32'd5, 32'hffff_fff0, 32'd9};
		foreach (conds[c]) begin
			foreach (lhs[p]) begin
				off = 13'($urandom);
				off[1:0] = 2'b00;
				do_transaction(rand_pc(), b_format(off, conds[c]), lhs[p], rhs[p]);
			end
		end
		for (int i = 0; i < 4; i++) begin
			joff = 21'($urandom);
			joff[1:0] = 2'b00;
			do_transaction(rand_pc(), j_format(joff), $urandom, $urandom);
			// Bit 0 of the sum is dropped by JALR
			imm = 12'($urandom);
			imm[1] = 1'b0;
			do_transaction(rand_pc(), i_format(imm, 3'b000, OPC_JALR), rand_pc(), $urandom);
		end
	endtask

	task automatic trap_tests;
		logic [6:0] bad_opc [4];
		inst_t      inst;
		bad_opc = '{7'b0001111, 7'b0101111, 7'b1111111, 7'b0000000};
		do_transaction(rand_pc(), INST_ECALL, $urandom, $urandom);
		do_transaction(rand_pc(), INST_EBREAK, $urandom, $urandom);
		foreach (bad_opc[k]) begin
			inst = inst_t'($urandom);
			inst[6:0] = bad_opc[k];
			do_transaction(rand_pc(), inst, $urandom, $urandom);
		end
		do_transaction(rand_pc(), i_format(12'($urandom), 3'b011, OPC_LOAD), $urandom, 0);
		do_transaction(rand_pc(), s_format(12'($urandom), 3'b100), $urandom, $urandom);
		do_transaction(rand_pc(), b_format(13'($urandom), 3'b010), $urandom, $urandom);
		do_transaction(rand_pc(), i_format(12'($urandom), 3'b001, OPC_JALR), $urandom, 0);
		do_transaction(rand_pc(), r_format(7'b0000001, F3_XOR, OPC_OP), $urandom, $urandom);
		do_transaction(rand_pc(), i_format(12'h403, F3_SLL, OPC_OP_IMM), $urandom, 0);
		do_transaction(rand_pc(), i_format(12'($urandom), 3'b001, OPC_SYSTEM), $urandom, 0);
		// Random words cover whatever decode case they land in
		for (int i = 0; i < 16; i++) begin
			do_transaction(rand_pc(), inst_t'($urandom) | 32'h3, $urandom, $urandom);
		end
	endtask

	task automatic misalign_tests;
		funct3_t     load_sizes [5];
		funct3_t     store_sizes [3];
		logic [20:0] joff;
		logic [12:0] off;
		logic [11:0] imm;
		load_sizes = '{F3_SIZE_B, F3_SIZE_H, F3_SIZE_W, F3_SIZE_BU, F3_SIZE_HU};
		store_sizes = '{F3_SIZE_B, F3_SIZE_H, F3_SIZE_W};
		joff = 21'($urandom);
		joff[1:0] = 2'b10;
		do_transaction(rand_pc(), j_format(joff), $urandom, $urandom);
		imm = 12'($urandom);
		imm[1:0] = 2'b11;
		do_transaction(rand_pc(), i_format(imm, 3'b000, OPC_JALR), rand_pc(), $urandom);
		off = 13'($urandom);
		off[1:0] = 2'b10;
		do_transaction(rand_pc(), b_format(off, F3_BEQ), 32'd9, 32'd9);
		// Not taken, so the odd target must not trap
		do_transaction(rand_pc(), b_format(off, F3_BNE), 32'd9, 32'd9);
		for (int ofs = 0; ofs < 4; ofs++) begin
			foreach (load_sizes[s]) begin
				imm = 12'($urandom);
				imm[1:0] = 2'(ofs);
				do_transaction(rand_pc(), i_format(imm, load_sizes[s], OPC_LOAD), rand_pc(), 0);
			end
			foreach (store_sizes[s]) begin
				imm = 12'($urandom);
				imm[1:0] = 2'(ofs);
				do_transaction(rand_pc(), s_format(imm, store_sizes[s]), rand_pc(), $urandom);
			end
		end
		// Illegal wins over a misaligned target or address
		do_transaction(rand_pc(), i_format(12'h002, 3'b010, OPC_JALR), rand_pc(), 0);
		do_transaction(rand_pc(), s_format(12'h001, F3_SIZE_HU), rand_pc(), $urandom);
	endtask

	initial begin
		void'($urandom(32'hda00));
		clk = 1'b0;
		rst = 1'b0;
		i_req = 1'b0;
		i_pc = '0;
		i_inst = '0;
		i_rs1_data = '0;
		i_rs2_data = '0;
		err_value = 0;
		err_handshake = 0;
		err_timeout = 0;
		n_trans = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		check_idle();
		rst = 1'b1;
		@(negedge clk);
		check_idle();
		alu_tests();
		branch_tests();
		trap_tests();
		misalign_tests();
		repeat (3) @(negedge clk);
		finish_run();
	end

endmodule

/* src/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit (
	input  logic             clk,
	input  logic             rst,
	input  logic             i_req,
	input  isa_pkg::addr_t   i_pc,
	input  isa_pkg::inst_t   i_inst,
	input  isa_pkg::word_t   i_rs1_data,
	input  isa_pkg::word_t   i_rs2_data,
	output logic             o_ack,
	output isa_pkg::word_t   o_result,
	output isa_pkg::addr_t   o_mem_addr,
	output logic             o_redirect,
	output isa_pkg::addr_t   o_target,
	output logic             o_expt_valid,
	output trap_pkg::cause_t o_expt_cause,
	output isa_pkg::word_t   o_expt_value
);
	import isa_pkg::*;
	import trap_pkg::*;

	// ALU path to merge
	word_t   alu_result;
	addr_t   alu_mem_addr;
	logic    alu_br_taken;
	addr_t   alu_target;
	logic    alu_is_jump;
	logic    alu_is_load;
	logic    alu_is_store;
	funct3_t alu_size;

	// Decode exception to merge
	logic    dec_expt_valid;
	cause_t  dec_cause;
	word_t   dec_value;

	alu_path alu_path_inst (
		.i_pc       (i_pc),
		.i_inst     (i_inst),
		.i_rs1_data (i_rs1_data),
		.i_rs2_data (i_rs2_data),
		.o_result   (alu_result),
		.o_mem_addr (alu_mem_addr),
		.o_br_taken (alu_br_taken),
		.o_target   (alu_target),
		.o_is_jump  (alu_is_jump),
		.o_is_load  (alu_is_load),
		.o_is_store (alu_is_store),
		.o_size     (alu_size)
	);

	trap_check trap_check_inst (
		.i_pc         (i_pc),
		.i_inst       (i_inst),
		.o_expt_valid (dec_expt_valid),
		.o_cause      (dec_cause),
		.o_value      (dec_value)
	);

	result_merge result_merge_inst (
		.clk          (clk),
		.rst          (rst),
		.i_req        (i_req),
		.i_result     (alu_result),
		.i_mem_addr   (alu_mem_addr),
		.i_br_taken   (alu_br_taken),
		.i_target     (alu_target),
		.i_is_jump    (alu_is_jump),
		.i_is_load    (alu_is_load),
		.i_is_store   (alu_is_store),
		.i_size       (alu_size),
		.i_expt_valid (dec_expt_valid),
		.i_cause      (dec_cause),
		.i_value      (dec_value),
		.o_ack        (o_ack),
		.o_result     (o_result),
		.o_mem_addr   (o_mem_addr),
		.o_redirect   (o_redirect),
		.o_target     (o_target),
		.o_expt_valid (o_expt_valid),
		.o_expt_cause (o_expt_cause),
		.o_expt_value (o_expt_value)
	);

endmodule

/* src/result_merge.sv */
`timescale 1ns/1ps

module result_merge (
	input  logic             clk,
	input  logic             rst,
	input  logic             i_req,
	input  isa_pkg::word_t   i_result,
	input  isa_pkg::addr_t   i_mem_addr,
	input  logic             i_br_taken,
	input  isa_pkg::addr_t   i_target,
	input  logic             i_is_jump,
	input  logic             i_is_load,
	input  logic             i_is_store,
	input  isa_pkg::funct3_t i_size,
	input  logic             i_expt_valid,
	input  trap_pkg::cause_t i_cause,
	input  isa_pkg::word_t   i_value,
	output logic             o_ack,
	output isa_pkg::word_t   o_result,
	output isa_pkg::addr_t   o_mem_addr,
	output logic             o_redirect,
	output isa_pkg::addr_t   o_target,
	output logic             o_expt_valid,
	output trap_pkg::cause_t o_expt_cause,
	output isa_pkg::word_t   o_expt_value
);
	import isa_pkg::*;
	import trap_pkg::*;

	typedef enum logic {
		IDLE,
		ACK
	} merge_state_t;

	merge_state_t state;
	logic         taken;
	logic         inst_misaligned;
	logic         mem_misaligned;
	logic         nxt_expt_valid;
	cause_t       nxt_cause;
	word_t        nxt_value;

	// Jumps always transfer control
	assign taken           = i_is_jump | i_br_taken;
	assign inst_misaligned = taken && (i_target[1:0] != 2'b00);

	always_comb begin
		mem_misaligned = 1'b0;
		if (i_is_load || i_is_store) begin
			case (i_size)
				F3_SIZE_H, F3_SIZE_HU: mem_misaligned = i_mem_addr[0];
				F3_SIZE_W:             mem_misaligned = (i_mem_addr[1:0] != 2'b00);
				default:               mem_misaligned = 1'b0;
			endcase
		end
	end

	// Decode first, then jump target, then data address
	always_comb begin
		nxt_expt_valid = i_expt_valid | inst_misaligned | mem_misaligned;
		nxt_cause      = i_cause;
		nxt_value      = i_value;
		if (!i_expt_valid) begin
			if (inst_misaligned) begin
				nxt_cause = CAUSE_INST_MISALIGNED;
				nxt_value = i_target;
			end else if (mem_misaligned) begin
				nxt_cause = i_is_load ? CAUSE_LOAD_MISALIGNED : CAUSE_STORE_MISALIGNED;
				nxt_value = i_mem_addr;
			end
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state        <= IDLE;
			o_result     <= '0;
			o_mem_addr   <= '0;
			o_redirect   <= 1'b0;
			o_target     <= '0;
			o_expt_valid <= 1'b0;
			o_expt_cause <= '0;
			o_expt_value <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (i_req) begin
						state        <= ACK;
						o_result     <= i_result;
						o_mem_addr   <= i_mem_addr;
						o_redirect   <= taken & ~nxt_expt_valid;
						o_target     <= i_target;
						o_expt_valid <= nxt_expt_valid;
						o_expt_cause <= nxt_cause;
						o_expt_value <= nxt_value;
					end
				end
				ACK: begin
					// Hold outputs until the requester lets go
					if (!i_req) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign o_ack = (state == ACK);

	a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst)
		$rose(o_ack) |-> $past(i_req));

	a_hold_stable: assert property (@(posedge clk) disable iff (!rst)
		o_ack && $past(o_ack) |-> $stable({o_result, o_mem_addr, o_redirect, o_target,
			o_expt_valid, o_expt_cause, o_expt_value}));

	a_redirect_xor_expt: assert property (@(posedge clk) disable iff (!rst)
		!(o_redirect && o_expt_valid));

endmodule

/* src/trap_check.sv */
`timescale 1ns/1ps

module trap_check (
	input  isa_pkg::addr_t   i_pc,
	input  isa_pkg::inst_t   i_inst,
	output logic             o_expt_valid,
	output trap_pkg::cause_t o_cause,
	output isa_pkg::word_t   o_value
);
	import isa_pkg::*;
	import trap_pkg::*;

	logic [6:0] opcode;
	logic [6:0] funct7;
	funct3_t    funct3;
	logic       is_ecall;
	logic       is_ebreak;
	logic       illegal;

	assign opcode    = i_inst[6:0];
	assign funct3    = i_inst[14:12];
	assign funct7    = i_inst[31:25];
	assign is_ecall  = (i_inst == INST_ECALL);
	assign is_ebreak = (i_inst == INST_EBREAK);

	always_comb begin
		illegal = 1'b0;
		case (opcode)
			OPC_OP: begin
				// ALT only for sub and sra
				illegal = !(funct7 == F7_BASE ||
					(funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA)));
			end
			OPC_OP_IMM: begin
				if (funct3 == F3_SLL) begin
					illegal = (funct7 != F7_BASE);
				end else if (funct3 == F3_SRL_SRA) begin
					illegal = (funct7 != F7_BASE) && (funct7 != F7_ALT);
				end
			end
			OPC_LUI, OPC_AUIPC, OPC_JAL: illegal = 1'b0;
			OPC_JALR:   illegal = (funct3 != '0);
			OPC_BRANCH: illegal = !(funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU});
			OPC_LOAD:   illegal = !(funct3 inside {F3_SIZE_B, F3_SIZE_H, F3_SIZE_W,
				F3_SIZE_BU, F3_SIZE_HU});
			OPC_STORE:  illegal = !(funct3 inside {F3_SIZE_B, F3_SIZE_H, F3_SIZE_W});
			OPC_SYSTEM: illegal = !(is_ecall || is_ebreak);
			default:    illegal = 1'b1;
		endcase
	end

	always_comb begin
		o_expt_valid = illegal | is_ecall | is_ebreak;
		o_cause      = '0;
		o_value      = '0;
		if (illegal) begin
			o_cause = CAUSE_ILLEGAL;
			o_value = word_t'(i_inst);
		end else if (is_ecall) begin
			o_cause = CAUSE_ECALL_M;
		end else if (is_ebreak) begin
			o_cause = CAUSE_BREAKPOINT;
			o_value = i_pc;
		end
	end

	a_decode_cause: assert final (!o_expt_valid ||
		o_cause inside {CAUSE_ILLEGAL, CAUSE_ECALL_M, CAUSE_BREAKPOINT})
		else $error("trap_check: unexpected decode cause %0d", o_cause);

endmodule

/* src/alu_path.sv */
`timescale 1ns/1ps

module alu_path (
	input  isa_pkg::addr_t   i_pc,
	input  isa_pkg::inst_t   i_inst,
	input  isa_pkg::word_t   i_rs1_data,
	input  isa_pkg::word_t   i_rs2_data,
	output isa_pkg::word_t   o_result,
	output isa_pkg::addr_t   o_mem_addr,
	output logic             o_br_taken,
	output isa_pkg::addr_t   o_target,
	output logic             o_is_jump,
	output logic             o_is_load,
	output logic             o_is_store,
	output isa_pkg::funct3_t o_size
);
	import isa_pkg::*;

	logic [6:0] opcode;
	funct3_t    funct3;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_u;
	word_t      imm_j;
	word_t      op1;
	word_t      op2;
	word_t      sum;
	word_t      alu_out;
	// Shift amount has the same 5-bit width as a register index
	reg_idx_t   shamt;
	logic       is_branch;
	logic       is_jal;
	logic       is_jalr;
	logic       is_jump;
	logic       br_cond;

	assign opcode = i_inst[6:0];
	assign funct3 = i_inst[14:12];

	assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
	assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
	assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
	assign imm_u = {i_inst[31:12], 12'b0};
	assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

	assign is_branch = (opcode == OPC_BRANCH);
	assign is_jal    = (opcode == OPC_JAL);
	assign is_jalr   = (opcode == OPC_JALR);
	assign is_jump   = is_jal | is_jalr;

	// Operand selection by format
	always_comb begin
		case (opcode)
			OPC_OP_IMM, OPC_LOAD, OPC_JALR: begin
				op1 = i_rs1_data;
				op2 = imm_i;
			end
			OPC_STORE: begin
				op1 = i_rs1_data;
				op2 = imm_s;
			end
			OPC_LUI: begin
				op1 = '0;
				op2 = imm_u;
			end
			OPC_AUIPC: begin
				op1 = i_pc;
				op2 = imm_u;
			end
			OPC_JAL: begin
				op1 = i_pc;
				op2 = imm_j;
			end
			default: begin
				op1 = i_rs1_data;
				op2 = i_rs2_data;
			end
		endcase
	end

	assign sum   = op1 + op2;
	assign shamt = op2[4:0];

	// Only OP and OP-IMM decode funct3, everything else adds
	always_comb begin
		alu_out = sum;
		if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
			case (funct3)
				F3_ADD_SUB: alu_out = (opcode == OPC_OP && i_inst[30]) ? op1 - op2 : sum;
				F3_SLL:     alu_out = op1 << shamt;
				F3_SLT:     alu_out = {{(XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
				F3_SLTU:    alu_out = {{(XLEN-1){1'b0}}, op1 < op2};
				F3_XOR:     alu_out = op1 ^ op2;
				F3_SRL_SRA: alu_out = i_inst[30] ? word_t'($signed(op1) >>> shamt) : op1 >> shamt;
				F3_OR:      alu_out = op1 | op2;
				F3_AND:     alu_out = op1 & op2;
				default:    alu_out = sum;
			endcase
		end
	end

	always_comb begin
		case (funct3)
			F3_BEQ:  br_cond = (op1 == op2);
			F3_BNE:  br_cond = (op1 != op2);
			F3_BLT:  br_cond = ($signed(op1) < $signed(op2));
			F3_BGE:  br_cond = ($signed(op1) >= $signed(op2));
			F3_BLTU: br_cond = (op1 < op2);
			F3_BGEU: br_cond = (op1 >= op2);
			default: br_cond = 1'b0;
		endcase
	end

	// Link address replaces the ALU result for jumps
	assign o_result   = is_jump ? i_pc + addr_t'(INST_BYTES) : alu_out;
	assign o_mem_addr = sum;
	assign o_target   = is_jalr ? {sum[XLEN-1:1], 1'b0} : i_pc + (is_branch ? imm_b : imm_j);
	assign o_br_taken = is_jump | (is_branch & br_cond);
	assign o_is_jump  = is_jump;
	assign o_is_load  = (opcode == OPC_LOAD);
	assign o_is_store = (opcode == OPC_STORE);
	assign o_size     = funct3;

endmodule

/* src/trap_pkg.sv */
package trap_pkg;

	typedef logic [3:0] cause_t;

	// Decode-level causes
	localparam cause_t CAUSE_ILLEGAL    = 4'd2;
	localparam cause_t CAUSE_BREAKPOINT = 4'd3;
	localparam cause_t CAUSE_ECALL_M    = 4'd11;

	// Execute-level causes
	localparam cause_t CAUSE_INST_MISALIGNED  = 4'd0;
	localparam cause_t CAUSE_LOAD_MISALIGNED  = 4'd4;
	localparam cause_t CAUSE_STORE_MISALIGNED = 4'd6;

endpackage

/* src/isa_pkg.sv */
package isa_pkg;

	localparam int XLEN = 32;
	localparam int ILEN = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [XLEN-1:0] addr_t;
	typedef logic [ILEN-1:0] inst_t;
	typedef logic [4:0]      reg_idx_t;
	typedef logic [2:0]      funct3_t;

	// Major opcodes, low two bits always 11
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// Full SYSTEM encodings that are accepted
	localparam inst_t INST_ECALL  = 32'h0000_0073;
	localparam inst_t INST_EBREAK = 32'h0010_0073;

	// Link increment for JAL and JALR
	localparam int unsigned INST_BYTES = 4;

	// ALU operations
	localparam funct3_t F3_ADD_SUB = 3'b000;
	localparam funct3_t F3_SLL     = 3'b001;
	localparam funct3_t F3_SLT     = 3'b010;
	localparam funct3_t F3_SLTU    = 3'b011;
	localparam funct3_t F3_XOR     = 3'b100;
	localparam funct3_t F3_SRL_SRA = 3'b101;
	localparam funct3_t F3_OR      = 3'b110;
	localparam funct3_t F3_AND     = 3'b111;

	// Branch conditions
	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	// Load/store access sizes
	localparam funct3_t F3_SIZE_B  = 3'b000;
	localparam funct3_t F3_SIZE_H  = 3'b001;
	localparam funct3_t F3_SIZE_W  = 3'b010;
	localparam funct3_t F3_SIZE_BU = 3'b100;
	localparam funct3_t F3_SIZE_HU = 3'b101;

	// funct7 for OP and shifts
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage
